// ==== exec_stage.f ====
+incdir+source
source/exec_pkg.sv
source/exec_decode.sv
source/exec_alu.sv
source/exec_branch.sv
source/exec_writeback.sv
source/exec_stage.sv
test/exec_stage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it.
# Exits non-zero on a build error, a simulator error or a failed test.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        -f exec_stage.f \
        --top-module exec_stage_tb \
        -o exec_stage_sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/exec_stage_sim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// ==== test/exec_stage_tb.sv ====
/*
 * Execute stage testbench
 * Random ALU, branch and jump instructions checked against a reference
 * model, with a delayed control flow acknowledge and a watchdog.
 */

`include "exec_cfg.svh"

module exec_stage_tb
    import exec_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_ALU    = 40;
    localparam int N_BRANCH = 36;  // Six of each branch kind
    localparam int N_JUMP   = 16;
    localparam int N_BPRESS = 12;
    localparam int N_ALIGN  = 12;
    localparam int N_MIX    = 24;
    localparam int N_INSTR  = N_ALU + N_BRANCH + N_JUMP + N_BPRESS + N_ALIGN + N_MIX;
    localparam int TIMEOUT_CYCLES = N_INSTR * 6 + 50; // Worst case 6 cycles per instr

    typedef struct packed {
        logic                  wen;    // GPR write expected
        logic [`EXEC_XLEN-1:0] wdata;
        logic                  cf;     // CF change expected
        logic [`EXEC_XLEN-1:0] target;
        logic                  trap;
        logic [1:0]            ret;    // instr_ret pulses for this instr
    } expect_t;

    logic                        g_clk;
    logic                        g_resetn;
    logic                        s2_valid;
    logic                        s2_full;
    exec_req_t                   s2_req;
    logic [`EXEC_XLEN-1:0]       mtvec_base;
    logic                        s2_cf_ack;
    logic                        s2_ready;
    logic                        s2_cf_valid;
    cf_bus_t                     s2_cf;
    logic                        s2_rd_wen;
    logic [`EXEC_REG_ADDR_W-1:0] s2_rd_addr;
    logic [`EXEC_XLEN-1:0]       s2_rd_wdata;
    logic                        trap_cpu;
    logic                        instr_ret;

    int        seed = 96;
    int        err_cnt, check_cnt, instr_cnt, test_cnt, test_fail_cnt;
    int        ret_total, ret_expected;
    int        wen_cnt, cf_cnt, ret_cnt;          // Per instr, cleared on accept
    logic      cf_acked;
    logic      smp_accept, smp_cf_valid, smp_cf_ack; // Rising edge samples
    expect_t   cur_exp;
    exec_req_t cur_req;
    string     test_name;
    int        test_err_start, test_instr_start;

    exec_stage exec_stage_inst (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .s2_valid    (s2_valid),
        .s2_full     (s2_full),
        .s2_req      (s2_req),
        .mtvec_base  (mtvec_base),
        .s2_cf_ack   (s2_cf_ack),
        .s2_ready    (s2_ready),
        .s2_cf_valid (s2_cf_valid),
        .s2_cf       (s2_cf),
        .s2_rd_wen   (s2_rd_wen),
        .s2_rd_addr  (s2_rd_addr),
        .s2_rd_wdata (s2_rd_wdata),
        .trap_cpu    (trap_cpu),
        .instr_ret   (instr_ret)
    );

    always #10 g_clk = ~g_clk; // 20 ns period

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    function automatic expect_t predict_result(input exec_req_t r, input logic full,
                                               input logic [`EXEC_XLEN-1:0] mtvec);
        expect_t     e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] alu_val;
        logic [31:0] tgt;
        logic        taken;
        a = r.opr_a;
        b = r.opr_b;
        e = '0;
        case (r.alu_op)
            ALU_ADD:  alu_val = a + b;
            ALU_SUB:  alu_val = a - b;
            ALU_XOR:  alu_val = a ^ b;
            ALU_OR:   alu_val = a | b;
            ALU_AND:  alu_val = a & b;
            ALU_SLT:  alu_val = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: alu_val = {31'b0, a < b};
            ALU_SRL:  alu_val = a >> b[4:0];
            ALU_SLL:  alu_val = a << b[4:0];
            ALU_SRA: begin
                alu_val = a >> b[4:0];
                if (a[31]) alu_val = alu_val | ~(32'hffff_ffff >> b[4:0]); // Sign fill
            end
            default:  alu_val = '0;
        endcase
        case (r.cfu_op)
            CFU_J, CFU_JAL, CFU_JALR: taken = 1'b1;
            CFU_BEQ:  taken = (a == b);
            CFU_BNE:  taken = (a != b);
            CFU_BLT:  taken = ($signed(a) < $signed(b));
            CFU_BLTU: taken = (a < b);
            CFU_BGE:  taken = ($signed(a) >= $signed(b));
            CFU_BGEU: taken = (a >= b);
            default:  taken = 1'b0;
        endcase
        if (r.cfu_op == CFU_J || r.cfu_op == CFU_JAL || r.cfu_op == CFU_JALR) begin
            tgt = a + b;
        end else begin
            tgt = r.pc + r.opr_c;                         // Branch offset from pc
        end
        if (r.cfu_op == CFU_JALR) tgt[0] = 1'b0;
        e.cf     = taken;
        e.trap   = taken && tgt[0];                       // Misaligned target
        e.target = e.trap ? mtvec : tgt;
        if (r.cfu_op == CFU_JAL || r.cfu_op == CFU_JALR) begin
            e.wen   = 1'b1;
            e.wdata = r.opr_c;                            // Link value
        end else if (r.alu_op != ALU_NOP && r.cfu_op == CFU_NOP) begin
            e.wen   = 1'b1;
            e.wdata = alu_val;
        end
        e.ret = e.trap ? 2'd0 : ({1'b0, full} + {1'b0, e.cf});
        return e;
    endfunction

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------

    task automatic compare_bit(input string name, input logic got, input logic want);
        check_cnt++;
        assert (got === want) else begin
            $display("MISMATCH at %0d ns: %s is %b, expected %b", $time, name, got, want);
            err_cnt++;
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        check_cnt++;
        assert (got === want) else begin
            $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, name, got, want);
            err_cnt++;
        end
    endtask

    always @(posedge g_clk) begin
        smp_accept   = s2_valid && s2_ready;
        smp_cf_valid = s2_cf_valid;
        smp_cf_ack   = s2_cf_ack;
        if (g_resetn && !s2_valid) begin
            compare_bit("s2_cf_valid", s2_cf_valid, 1'b0); // Idle stage stays quiet
            compare_bit("s2_rd_wen", s2_rd_wen, 1'b0);
            compare_bit("trap_cpu", trap_cpu, 1'b0);
            compare_bit("instr_ret", instr_ret, 1'b0);
        end else if (g_resetn) begin
            compare_bit("trap_cpu", trap_cpu, cur_exp.trap);
            compare_bit("s2_cf_valid", s2_cf_valid, cur_exp.cf && !cf_acked);
            if (s2_rd_wen) begin
                compare_word("s2_rd_wdata", s2_rd_wdata, cur_exp.wdata);
                compare_word("s2_rd_addr", 32'(s2_rd_addr), 32'(cur_req.rd));
                wen_cnt++;
            end
            if (s2_cf_valid) begin
                compare_word("s2_cf.target", s2_cf.target, cur_exp.target); // Held steady
                compare_bit("s2_ready", s2_ready, 1'b0);
                if (cur_exp.trap) begin
                    compare_word("s2_cf.cause", 32'(s2_cf.cause), `EXEC_TRAP_FETCH_ALIGN);
                end
                if (s2_cf_ack) begin
                    cf_acked = 1'b1;
                    cf_cnt++;
                end
            end
            if (!cur_exp.cf) compare_bit("s2_ready", s2_ready, 1'b1); // Same cycle
            if (instr_ret) ret_cnt++;
            if (s2_ready) begin                               // Instr accepted
                compare_word("s2_rd_wen pulses", wen_cnt, 32'(cur_exp.wen));
                compare_word("CF changes", cf_cnt, 32'(cur_exp.cf));
                compare_word("instr_ret pulses", ret_cnt, 32'(cur_exp.ret));
                ret_total += ret_cnt;
                wen_cnt   = 0;
                cf_cnt    = 0;
                ret_cnt   = 0;
                cf_acked  = 1'b0;
                instr_cnt++;
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic exec_req_t random_req();
        exec_req_t r;
        r        = '0;
        r.pc     = rand_word() & ~32'h1;   // Even pc
        r.opr_a  = rand_word();
        r.opr_b  = rand_word();
        r.opr_c  = rand_word() & ~32'h1;   // Even offset, aligned branch target
        r.rd     = 5'(rand_word());
        r.alu_op = ALU_NOP;
        r.cfu_op = CFU_NOP;
        return r;
    endfunction

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic drive_instr(input exec_req_t req, input logic full, input int delay);
        int unsigned ack_delay;
        int unsigned seen;
        logic        accepted;
        s2_valid  = 1'b1;
        s2_full   = full;
        s2_req    = req;
        s2_cf_ack = 1'b0;
        cur_req   = req;
        cur_exp   = predict_result(req, full, mtvec_base);
        ret_expected += int'(cur_exp.ret);
        ack_delay = (delay < 0) ? ($random(seed) & 3) : delay;
        seen      = 0;
        accepted  = 1'b0;
        while (!accepted) begin
            @(negedge g_clk);
            s2_cf_ack = 1'b0;                  // Ack is a single cycle
            if (smp_accept) begin
                accepted = 1'b1;
            end else if (smp_cf_valid && !smp_cf_ack) begin
                if (seen == ack_delay) begin
                    s2_cf_ack = 1'b1;
                end else begin
                    seen++;
                end
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        s2_valid  = 1'b0;
        s2_full   = 1'b0;
        s2_req    = '0;                        // NOP for both ops
        s2_cf_ack = 1'b0;
        repeat (n) @(negedge g_clk);
    endtask

    task automatic begin_test(input string name);
        test_name        = name;
        test_err_start   = err_cnt;
        test_instr_start = instr_cnt;
    endtask

    task automatic end_test();
        int errs;
        idle_cycles(2);
        errs = err_cnt - test_err_start;
        test_cnt++;
        if (errs != 0) test_fail_cnt++;
        $display("Test %-12s %0d instructions, %0d errors", test_name,
                 instr_cnt - test_instr_start, errs);
    endtask

    initial begin
        exec_req_t   req;
        logic [31:0] rnd;
        int          k;
        g_clk        = 1'b0;
        g_resetn     = 1'b0;
        mtvec_base   = 32'h0000_0200;
        cf_acked     = 1'b0;
        smp_accept   = 1'b0;
        smp_cf_valid = 1'b0;
        smp_cf_ack   = 1'b0;
        idle_cycles(4);                        // Reset held for 4 cycles
        g_resetn = 1'b1;

        begin_test("alu");
        for (int i = 0; i < N_ALU; i++) begin
            req        = random_req();
            req.alu_op = alu_op_t'(4'(rand_word() % 10 + 1));
            drive_instr(req, 1'b1, -1);
        end
        end_test();

        begin_test("branch");
        for (int i = 0; i < N_BRANCH; i++) begin
            req        = random_req();
            req.cfu_op = cfu_op_t'(4'(4 + i % 6)); // BEQ through BGEU
            rnd        = rand_word();
            if (rnd[0]) req.opr_b = req.opr_a;     // Equal operands half the time
            drive_instr(req, rnd[1], -1);
        end
        end_test();

        begin_test("jump");
        for (int i = 0; i < N_JUMP; i++) begin
            req        = random_req();
            req.cfu_op = (i % 2 == 0) ? CFU_JAL : CFU_JALR;
            if (req.cfu_op == CFU_JAL) req.opr_b[0] = req.opr_a[0]; // Even sum
            drive_instr(req, 1'b1, -1);
        end
        end_test();

        begin_test("backpressure");
        for (int i = 0; i < N_BPRESS; i++) begin
            req          = random_req();
            req.cfu_op   = (i % 3 == 0) ? CFU_J : (i % 3 == 1) ? CFU_JAL : CFU_BNE;
            req.opr_b[0] = req.opr_a[0];
            if (req.cfu_op == CFU_BNE) req.opr_b = ~req.opr_a; // Always taken
            drive_instr(req, 1'b1, 3);                          // Longest ack wait
        end
        end_test();

        begin_test("misaligned");
        for (int i = 0; i < N_ALIGN; i++) begin
            req          = random_req();
            req.cfu_op   = (i % 3 == 0) ? CFU_J : (i % 3 == 1) ? CFU_JAL : CFU_BEQ;
            req.opr_b[0] = ~req.opr_a[0];      // Odd jump target
            if (req.cfu_op == CFU_BEQ) begin
                req.opr_b    = req.opr_a;
                req.opr_c[0] = 1'b1;           // Odd branch target
            end
            drive_instr(req, 1'b1, -1);
        end
        end_test();

        begin_test("retire");
        for (int i = 0; i < N_MIX; i++) begin
            req        = random_req();
            k          = rand_word() % 10;
            req.cfu_op = cfu_op_t'(4'(k));
            if (k == 0) req.alu_op = alu_op_t'(4'(rand_word() % 11));
            rnd = rand_word();
            drive_instr(req, rnd[0], -1);
        end
        end_test();

        compare_word("instr_ret total", ret_total, ret_expected);
        $display("Done: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_cnt, test_fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge g_clk);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== source/exec_stage.sv ====
/*
 * Execute stage top level
 * Chains decode, ALU, control flow and writeback within one cycle.
 */

`include "exec_cfg.svh"

module exec_stage
    import exec_pkg::*;
(
    input  logic                        g_clk,
    input  logic                        g_resetn,
    input  logic                        s2_valid,    // Decode instr ready for execute
    input  logic                        s2_full,     // Instr present in stage regs
    input  exec_req_t                   s2_req,      // Operands, rd and ops
    input  logic [`EXEC_XLEN-1:0]       mtvec_base,
    input  logic                        s2_cf_ack,
    output logic                        s2_ready,
    output logic                        s2_cf_valid,
    output cf_bus_t                     s2_cf,
    output logic                        s2_rd_wen,
    output logic [`EXEC_REG_ADDR_W-1:0] s2_rd_addr,
    output logic [`EXEC_XLEN-1:0]       s2_rd_wdata,
    output logic                        trap_cpu,
    output logic                        instr_ret
);

    exec_ctl_t ctl;       // Decode to the rest
    alu_res_t  alu_res;   // ALU to branch and writeback
    logic      new_instr; // Branch to writeback

    // ----------------------------------------------------------------------
    // Sub-stage chain
    // ----------------------------------------------------------------------

    exec_decode exec_decode_inst (
        .alu_op (s2_req.alu_op),
        .cfu_op (s2_req.cfu_op),
        .ctl    (ctl)
    );

    exec_alu exec_alu_inst (
        .opr_a (s2_req.opr_a),
        .opr_b (s2_req.opr_b),
        .ctl   (ctl),
        .res   (alu_res)
    );

    exec_branch exec_branch_inst (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .s2_valid    (s2_valid),
        .s2_full     (s2_full),
        .pc          (s2_req.pc),
        .opr_c       (s2_req.opr_c),
        .ctl         (ctl),
        .alu         (alu_res),
        .mtvec_base  (mtvec_base),
        .s2_cf_ack   (s2_cf_ack),
        .s2_cf_valid (s2_cf_valid),
        .s2_cf       (s2_cf),
        .s2_ready    (s2_ready),
        .new_instr   (new_instr),
        .trap_cpu    (trap_cpu),
        .instr_ret   (instr_ret)
    );

    exec_writeback exec_writeback_inst (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .s2_valid    (s2_valid),
        .new_instr   (new_instr),
        .ctl         (ctl),
        .alu_result  (alu_res.result),
        .opr_c       (s2_req.opr_c),     // Link value for JAL/JALR
        .rd          (s2_req.rd),
        .s2_rd_wen   (s2_rd_wen),
        .s2_rd_addr  (s2_rd_addr),
        .s2_rd_wdata (s2_rd_wdata)
    );

endmodule

// ==== source/exec_writeback.sv ====
/*
 * Execute stage writeback
 * Selects the GPR write data and limits the write to once per instr.
 */

`include "exec_cfg.svh"

module exec_writeback
    import exec_pkg::*;
(
    input  logic                        g_clk,
    input  logic                        g_resetn,
    input  logic                        s2_valid,    // Instr valid in stage
    input  logic                        new_instr,   // Stage takes a new instr
    input  exec_ctl_t                   ctl,
    input  logic [`EXEC_XLEN-1:0]       alu_result,
    input  logic [`EXEC_XLEN-1:0]       opr_c,       // Link value
    input  logic [`EXEC_REG_ADDR_W-1:0] rd,
    output logic                        s2_rd_wen,   // GPR write enable
    output logic [`EXEC_REG_ADDR_W-1:0] s2_rd_addr,  // GPR write address
    output logic [`EXEC_XLEN-1:0]       s2_rd_wdata  // GPR write data
);

    localparam int XLEN = `EXEC_XLEN;

    logic rd_done;
    logic src_active;

    // ----------------------------------------------------------------------
    // Write data select
    // ----------------------------------------------------------------------

    assign src_active = ctl.link || ctl.alu_wen; // Link and ALU never both

    assign s2_rd_wdata = ({XLEN{ctl.link   }} & opr_c     ) |
                         ({XLEN{ctl.alu_wen}} & alu_result);

    assign s2_rd_addr  = rd;

    // ----------------------------------------------------------------------
    // Once per instr
    // ----------------------------------------------------------------------

    assign s2_rd_wen = s2_valid && src_active && !rd_done;

    // Blocks repeat writes while the instr is held
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rd_done <= 1'b0;
        end else if (new_instr) begin
            rd_done <= 1'b0;
        end else if (s2_rd_wen) begin
            rd_done <= 1'b1;                     // Write done, hold off
        end
    end

endmodule

// ==== source/exec_branch.sv ====
/*
 * Execute stage control flow
 * Resolves branches and jumps, drives the control flow bus, flags
 * misaligned targets and decides when the stage can take a new instr.
 */

`include "exec_cfg.svh"

module exec_branch
    import exec_pkg::*;
(
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  s2_valid,    // Decode has an instr for us
    input  logic                  s2_full,     // Instr present in the stage
    input  logic [`EXEC_XLEN-1:0] pc,          // Execute stage PC
    input  logic [`EXEC_XLEN-1:0] opr_c,       // Branch offset
    input  exec_ctl_t             ctl,
    input  alu_res_t              alu,
    input  logic [`EXEC_XLEN-1:0] mtvec_base,  // Trap vector base
    input  logic                  s2_cf_ack,   // CF change accepted
    output logic                  s2_cf_valid, // CF change request level
    output cf_bus_t               s2_cf,
    output logic                  s2_ready,    // Can accept a new instr
    output logic                  new_instr,
    output logic                  trap_cpu,
    output logic                  instr_ret    // Instr retired
);

    localparam int XLEN = `EXEC_XLEN;

    logic            cf_change;
    logic            cf_done;
    logic            cfu_nop;
    logic            cond_taken;
    logic            not_taken;
    logic [XLEN-1:0] bcmp_target;
    logic [XLEN-1:0] jump_target;
    logic            bad_target;

    // ----------------------------------------------------------------------
    // Events
    // ----------------------------------------------------------------------

    assign new_instr = s2_valid && s2_ready;
    assign cf_change = s2_cf_valid && s2_cf_ack;

    // ----------------------------------------------------------------------
    // Branch resolve and targets
    // ----------------------------------------------------------------------

    assign cfu_nop    = !ctl.is_jump && !ctl.is_cond;

    assign cond_taken = (ctl.br_beq  &&  alu.cmp_eq ) ||
                        (ctl.br_bne  && !alu.cmp_eq ) ||
                        (ctl.br_blt  &&  alu.cmp_lt ) ||
                        (ctl.br_bltu &&  alu.cmp_ltu) ||
                        (ctl.br_bge  && !alu.cmp_lt ) ||
                        (ctl.br_bgeu && !alu.cmp_ltu);

    assign not_taken   = ctl.is_cond && !cond_taken;

    assign bcmp_target = pc + opr_c;                                     // Branch
    // JALR clears bit 0
    assign jump_target = {alu.add_out[XLEN-1:1], alu.add_out[0] && !ctl.is_jalr};

    // Misaligned target is the only exception left
    assign bad_target = (cond_taken && bcmp_target[0]) ||
                        (ctl.is_jump && !ctl.is_jalr && jump_target[0]);

    // ----------------------------------------------------------------------
    // Control flow bus
    // ----------------------------------------------------------------------

    // Stops a second CF change to the same target
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cf_done <= 1'b0;
        end else if (new_instr) begin
            cf_done <= 1'b0;                    // Next instr starts clean
        end else if (cf_change) begin
            cf_done <= 1'b1;
        end
    end

    assign s2_cf_valid = (cond_taken || ctl.is_jump) && !cf_done; // Traps ride on these

    assign s2_cf.target = bad_target  ? mtvec_base  :
                          ctl.is_cond ? bcmp_target :
                                        jump_target;
    assign s2_cf.cause  = CAUSE_FETCH_ALIGN;    // Only cause in use

    // ----------------------------------------------------------------------
    // Stage ready and status
    // ----------------------------------------------------------------------

    assign s2_ready  = cfu_nop || not_taken || cf_done; // No CF change left to make

    assign trap_cpu  = bad_target;
    assign instr_ret = ((new_instr && s2_full) || cf_change) && !bad_target;

endmodule

// ==== source/exec_alu.sv ====
/*
 * Execute stage integer ALU
 * Add, subtract, logic ops, set-less-than and shifts, plus the adder
 * output and compare flags used for branches and jump targets.
 */

`include "exec_cfg.svh"

module exec_alu
    import exec_pkg::*;
(
    input  logic [`EXEC_XLEN-1:0] opr_a, // Operand a
    input  logic [`EXEC_XLEN-1:0] opr_b, // Operand b
    input  exec_ctl_t             ctl,   // Uses the one-hot ALU selects
    output alu_res_t              res    // Result, sum and flags
);

    localparam int XLEN = `EXEC_XLEN;

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [4:0]      shamt;
    logic [XLEN-1:0] shr_l;
    logic [XLEN-1:0] shr_a;
    logic [XLEN-1:0] shl;
    logic            lt_s;
    logic            lt_u;

    // ----------------------------------------------------------------------
    // Arithmetic and compare
    // ----------------------------------------------------------------------

    assign sum   = opr_a + opr_b; // Also the jump target adder
    assign diff  = opr_a - opr_b;

    assign lt_s  = $signed(opr_a) < $signed(opr_b);
    assign lt_u  = opr_a < opr_b;

    // ----------------------------------------------------------------------
    // Shifter
    // ----------------------------------------------------------------------

    assign shamt = opr_b[4:0];                      // Low five bits only
    assign shr_l = opr_a >> shamt;
    assign shr_a = $unsigned($signed(opr_a) >>> shamt); // Sign fill
    assign shl   = opr_a << shamt;

    // ----------------------------------------------------------------------
    // Result select
    // ----------------------------------------------------------------------

    // Selects are one-hot, so an AND-OR mux is enough
    assign res.result =
        ({XLEN{ctl.alu.op_add }} & sum                    ) |
        ({XLEN{ctl.alu.op_sub }} & diff                   ) |
        ({XLEN{ctl.alu.op_xor }} & (opr_a ^ opr_b)        ) |
        ({XLEN{ctl.alu.op_or  }} & (opr_a | opr_b)        ) |
        ({XLEN{ctl.alu.op_and }} & (opr_a & opr_b)        ) |
        ({XLEN{ctl.alu.op_slt }} & {{(XLEN-1){1'b0}}, lt_s}) |
        ({XLEN{ctl.alu.op_sltu}} & {{(XLEN-1){1'b0}}, lt_u}) |
        ({XLEN{ctl.alu.op_srl }} & shr_l                  ) |
        ({XLEN{ctl.alu.op_sll }} & shl                    ) |
        ({XLEN{ctl.alu.op_sra }} & shr_a                  );

    // Always valid whatever the op
    assign res.add_out = sum;
    assign res.cmp_eq  = (opr_a == opr_b);
    assign res.cmp_lt  = lt_s;
    assign res.cmp_ltu = lt_u;

endmodule

// ==== source/exec_decode.sv ====
/*
 * Execute stage decode
 * Expands the ALU and control flow op codes into one-hot selects,
 * control flow class bits and the writeback source.
 */

module exec_decode
    import exec_pkg::*;
(
    input  alu_op_t   alu_op, // ALU operation
    input  cfu_op_t   cfu_op, // Control flow operation
    output exec_ctl_t ctl     // Expanded control word
);

    logic alu_nop;
    logic cfu_nop;

    assign alu_nop = (alu_op == ALU_NOP);
    assign cfu_nop = (cfu_op == CFU_NOP);

    // ----------------------------------------------------------------------
    // ALU selects
    // ----------------------------------------------------------------------

    assign ctl.alu.op_add  = (alu_op == ALU_ADD);
    assign ctl.alu.op_sub  = (alu_op == ALU_SUB);
    assign ctl.alu.op_xor  = (alu_op == ALU_XOR);
    assign ctl.alu.op_or   = (alu_op == ALU_OR);
    assign ctl.alu.op_and  = (alu_op == ALU_AND);
    assign ctl.alu.op_slt  = (alu_op == ALU_SLT);
    assign ctl.alu.op_sltu = (alu_op == ALU_SLTU);
    assign ctl.alu.op_srl  = (alu_op == ALU_SRL);
    assign ctl.alu.op_sll  = (alu_op == ALU_SLL);
    assign ctl.alu.op_sra  = (alu_op == ALU_SRA);

    // ----------------------------------------------------------------------
    // Control flow class
    // ----------------------------------------------------------------------

    assign ctl.br_beq  = (cfu_op == CFU_BEQ);
    assign ctl.br_bne  = (cfu_op == CFU_BNE);
    assign ctl.br_blt  = (cfu_op == CFU_BLT);
    assign ctl.br_bltu = (cfu_op == CFU_BLTU);
    assign ctl.br_bge  = (cfu_op == CFU_BGE);
    assign ctl.br_bgeu = (cfu_op == CFU_BGEU);

    assign ctl.is_jalr = (cfu_op == CFU_JALR);
    assign ctl.is_jump = (cfu_op == CFU_J) || (cfu_op == CFU_JAL) || ctl.is_jalr; // Unconditional
    assign ctl.is_cond = ctl.br_beq || ctl.br_bne  || ctl.br_blt ||
                         ctl.br_bltu || ctl.br_bge || ctl.br_bgeu;

    // Writeback source
    assign ctl.link    = (cfu_op == CFU_JAL) || ctl.is_jalr; // Link reg
    assign ctl.alu_wen = !alu_nop && cfu_nop;                 // Plain ALU op only

endmodule

// ==== source/exec_pkg.sv ====
/*
 * Execute stage types
 * Op encodings and the packed structs that pass between the decode,
 * ALU, control flow and writeback sub-stages.
 */

`include "exec_cfg.svh"

package exec_pkg;

    // ----------------------------------------------------------------------
    // Op encodings
    // ----------------------------------------------------------------------

    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_XOR  = 4'd3,
        ALU_OR   = 4'd4,
        ALU_AND  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SLL  = 4'd9,
        ALU_SRA  = 4'd10
    } alu_op_t;

    typedef enum logic [3:0] {
        CFU_NOP  = 4'd0,
        CFU_J    = 4'd1,
        CFU_JAL  = 4'd2,
        CFU_JALR = 4'd3,
        CFU_BEQ  = 4'd4,
        CFU_BNE  = 4'd5,
        CFU_BLT  = 4'd6,
        CFU_BLTU = 4'd7,
        CFU_BGE  = 4'd8,
        CFU_BGEU = 4'd9
    } cfu_op_t;

    // Fixed cause reported on a misaligned target
    localparam logic [`EXEC_CAUSE_W-1:0] CAUSE_FETCH_ALIGN = `EXEC_TRAP_FETCH_ALIGN;

    // ----------------------------------------------------------------------
    // Stage structs
    // ----------------------------------------------------------------------

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]       pc;     // Execute stage PC
        logic [`EXEC_XLEN-1:0]       opr_a;  // Operand a
        logic [`EXEC_XLEN-1:0]       opr_b;  // Operand b
        logic [`EXEC_XLEN-1:0]       opr_c;  // Branch offset or link value
        logic [`EXEC_REG_ADDR_W-1:0] rd;     // Destination register
        alu_op_t                     alu_op;
        cfu_op_t                     cfu_op;
    } exec_req_t;

    typedef struct packed {
        logic op_add;
        logic op_sub;
        logic op_xor;
        logic op_or;
        logic op_and;
        logic op_slt;
        logic op_sltu;
        logic op_srl;
        logic op_sll;
        logic op_sra;
    } alu_sel_t;

    typedef struct packed {
        alu_sel_t alu;     // One-hot ALU result select
        logic     is_jump; // J, JAL or JALR
        logic     is_jalr;
        logic     is_cond; // Any conditional branch
        logic     br_beq;
        logic     br_bne;
        logic     br_blt;
        logic     br_bltu;
        logic     br_bge;
        logic     br_bgeu;
        logic     link;    // Write pc+4 held in opr_c
        logic     alu_wen; // Write the ALU result
    } exec_ctl_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0] add_out; // Always opr_a + opr_b
        logic [`EXEC_XLEN-1:0] result;
        logic                  cmp_eq;
        logic                  cmp_lt;
        logic                  cmp_ltu;
    } alu_res_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]    target;
        logic [`EXEC_CAUSE_W-1:0] cause;
    } cf_bus_t;

endpackage

// ==== source/exec_cfg.svh ====
/*
 * Execute stage configuration
 * Data width, register address width and trap cause codes shared by
 * the execute stage package and its sub-stages.
 */

`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------

`define EXEC_XLEN             32 // Data and address width
`define EXEC_REG_ADDR_W       5  // GPR address width, 32 registers

// ----------------------------------------------------------------------
// Trap causes
// ----------------------------------------------------------------------

`define EXEC_CAUSE_W          7  // Width of the cause field on the CF bus

// Misaligned fetch target from a taken branch or a jump
`define EXEC_TRAP_FETCH_ALIGN 0

`endif
